// File: rtl/decode_pkg.sv
package decode_pkg;

    localparam logic [1:0] PLV_KERNEL = 2'd0;

    // 3R format, inst[31:15]
    localparam logic [16:0] OP_ADDW    = 17'h00020;
    localparam logic [16:0] OP_SUBW    = 17'h00022;
    localparam logic [16:0] OP_SLT     = 17'h00024;
    localparam logic [16:0] OP_SLTU    = 17'h00025;
    localparam logic [16:0] OP_NOR     = 17'h00028;
    localparam logic [16:0] OP_AND     = 17'h00029;
    localparam logic [16:0] OP_OR      = 17'h0002a;
    localparam logic [16:0] OP_XOR     = 17'h0002b;
    localparam logic [16:0] OP_SLLW    = 17'h0002e;
    localparam logic [16:0] OP_SRLW    = 17'h0002f;
    localparam logic [16:0] OP_SRAW    = 17'h00030;
    localparam logic [16:0] OP_MULW    = 17'h00038;
    localparam logic [16:0] OP_MULHW   = 17'h00039;
    localparam logic [16:0] OP_MULHWU  = 17'h0003a;
    localparam logic [16:0] OP_DIVW    = 17'h00040;
    localparam logic [16:0] OP_MODW    = 17'h00041;
    localparam logic [16:0] OP_DIVWU   = 17'h00042;
    localparam logic [16:0] OP_BREAK   = 17'h00054;
    localparam logic [16:0] OP_SYSCALL = 17'h00056;
    localparam logic [16:0] OP_SLLIW   = 17'h00081;
    localparam logic [16:0] OP_SRLIW   = 17'h00089;
    localparam logic [16:0] OP_SRAIW   = 17'h00091;
    localparam logic [16:0] OP_IDLE    = 17'h00c91;
    localparam logic [16:0] OP_INVTLB  = 17'h00c93;
    localparam logic [16:0] OP_DBAR    = 17'h070e4;
    localparam logic [16:0] OP_IBAR    = 17'h070e5;

    // 2RI12 format, inst[31:22]
    localparam logic [9:0] OP_SLTI  = 10'h008;
    localparam logic [9:0] OP_SLTUI = 10'h009;
    localparam logic [9:0] OP_ADDIW = 10'h00a;
    localparam logic [9:0] OP_ANDI  = 10'h00d;
    localparam logic [9:0] OP_ORI   = 10'h00e;
    localparam logic [9:0] OP_XORI  = 10'h00f;

    typedef enum logic [7:0] {
        ALU_NOP = 8'h00,
        ALU_ADDW, ALU_SUBW, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
        ALU_SLLW, ALU_SRLW, ALU_SRAW, ALU_SLLIW, ALU_SRLIW, ALU_SRAIW,
        ALU_MULW, ALU_MULHW, ALU_MULHWU, ALU_DIVW, ALU_DIVWU, ALU_MODW,
        ALU_BREAK, ALU_SYSCALL, ALU_IDLE, ALU_INVTLB
    } aluop_t;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'd0,
        SEL_ARITH = 3'd1,
        SEL_MUL   = 3'd2
    } alusel_t;

    typedef enum logic [6:0] {
        ECODE_ADEF = 7'h08,
        ECODE_SYS  = 7'h0b,
        ECODE_BRK  = 7'h0c,
        ECODE_INE  = 7'h0d,
        ECODE_IPE  = 7'h0e
    } ecode_t;

    typedef struct packed {
        logic        hit;
        logic        is_priv;
        logic        we;
        aluop_t      aluop;
        alusel_t     alusel;
        logic [31:0] imm;
        logic        re1;
        logic        re2;
        logic [4:0]  invtlb_op;
    } dec_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } in_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        we;
        logic [4:0]  waddr;
        aluop_t      aluop;
        alusel_t     alusel;
        logic [31:0] imm;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        is_priv;
        logic [4:0]  invtlb_op;
        logic        exc;
        ecode_t      ecode;
    } id_out_t;

endpackage

// File: rtl/id_3r.sv
module id_3r (
    input  logic [31:0]       inst,
    output decode_pkg::dec_t  dec
);
    import decode_pkg::*;

    logic [16:0] opcode;
    logic [4:0]  rd;
    logic [4:0]  ui5;

    assign opcode = inst[31:15];
    assign rd     = inst[4:0];
    assign ui5    = inst[14:10]; // shares bits with rk

    always_comb begin
        dec.hit       = 1'b1;
        dec.is_priv   = 1'b0;
        dec.we        = 1'b1;
        dec.aluop     = ALU_NOP;
        dec.alusel    = SEL_ARITH;
        dec.imm       = 32'b0;
        dec.re1       = 1'b1;
        dec.re2       = 1'b1;
        dec.invtlb_op = 5'b0;

        case (opcode)
            OP_ADDW:    dec.aluop = ALU_ADDW;
            OP_SUBW:    dec.aluop = ALU_SUBW;
            OP_AND:     dec.aluop = ALU_AND;
            OP_OR:      dec.aluop = ALU_OR;
            OP_XOR:     dec.aluop = ALU_XOR;
            OP_NOR:     dec.aluop = ALU_NOR;
            OP_SLT:     dec.aluop = ALU_SLT;
            OP_SLTU:    dec.aluop = ALU_SLTU;
            OP_SLLW:    dec.aluop = ALU_SLLW;
            OP_SRLW:    dec.aluop = ALU_SRLW;
            OP_SRAW:    dec.aluop = ALU_SRAW;
            OP_SLLIW:   dec.aluop = ALU_SLLIW;
            OP_SRLIW:   dec.aluop = ALU_SRLIW;
            OP_SRAIW:   dec.aluop = ALU_SRAIW;
            OP_MULW:    dec.aluop = ALU_MULW;
            OP_MULHW:   dec.aluop = ALU_MULHW;
            OP_MULHWU:  dec.aluop = ALU_MULHWU;
            OP_DIVW:    dec.aluop = ALU_DIVW;
            OP_DIVWU:   dec.aluop = ALU_DIVWU;
            OP_MODW:    dec.aluop = ALU_MODW;
            OP_BREAK:   dec.aluop = ALU_BREAK;
            OP_SYSCALL: dec.aluop = ALU_SYSCALL;
            OP_IDLE:    dec.aluop = ALU_IDLE;
            OP_INVTLB:  dec.aluop = ALU_INVTLB;
            OP_DBAR,
            OP_IBAR:    dec.aluop = ALU_NOP; // barriers retire as nop
            default:    dec.hit = 1'b0;
        endcase

        // per-class fields follow from the op
        case (dec.aluop)
            ALU_SLLIW, ALU_SRLIW, ALU_SRAIW: begin
                dec.re2 = 1'b0;
                dec.imm = {27'b0, ui5};
            end
            ALU_MULW, ALU_MULHW, ALU_MULHWU, ALU_DIVW, ALU_DIVWU, ALU_MODW: begin
                dec.alusel = SEL_MUL;
            end
            ALU_INVTLB: begin
                dec.we        = 1'b0;
                dec.alusel    = SEL_NOP;
                dec.is_priv   = 1'b1;
                dec.invtlb_op = rd; // op field sits in rd
            end
            ALU_IDLE: begin
                dec.we      = 1'b0;
                dec.alusel  = SEL_NOP;
                dec.re1     = 1'b0;
                dec.re2     = 1'b0;
                dec.is_priv = 1'b1;
            end
            ALU_BREAK, ALU_SYSCALL, ALU_NOP: begin
                dec.we     = 1'b0;
                dec.alusel = SEL_NOP;
                dec.re1    = 1'b0;
                dec.re2    = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/id_2ri12.sv
module id_2ri12 (
    input  logic [31:0]       inst,
    output decode_pkg::dec_t  dec
);
    import decode_pkg::*;

    logic [9:0]  opcode;
    logic [11:0] si12;

    assign opcode = inst[31:22];
    assign si12   = inst[21:10];

    always_comb begin
        dec.hit       = 1'b1;
        dec.is_priv   = 1'b0;
        dec.we        = 1'b1;
        dec.aluop     = ALU_NOP;
        dec.alusel    = SEL_ARITH;
        dec.imm       = {{20{si12[11]}}, si12};
        dec.re1       = 1'b1;
        dec.re2       = 1'b0; // imm replaces rk
        dec.invtlb_op = 5'b0;

        case (opcode)
            OP_ADDIW: dec.aluop = ALU_ADDW;
            OP_SLTI:  dec.aluop = ALU_SLT;
            OP_SLTUI: dec.aluop = ALU_SLTU;
            OP_ANDI: begin
                dec.aluop = ALU_AND;
                dec.imm   = {20'b0, si12};
            end
            OP_ORI: begin
                dec.aluop = ALU_OR;
                dec.imm   = {20'b0, si12};
            end
            OP_XORI: begin
                dec.aluop = ALU_XOR;
                dec.imm   = {20'b0, si12};
            end
            default: begin
                dec.hit    = 1'b0;
                dec.we     = 1'b0;
                dec.alusel = SEL_NOP;
                dec.imm    = 32'b0;
                dec.re1    = 1'b0;
            end
        endcase
    end

endmodule

// File: rtl/regfile.sv
module regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass from the write port
    assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : regs[raddr2];

endmodule

// File: rtl/id_ctrl.sv
module id_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  decode_pkg::in_t      in,
    input  logic [1:0]           plv,
    input  decode_pkg::dec_t     dec_3r,
    input  decode_pkg::dec_t     dec_2ri12,
    output logic [4:0]           raddr1,
    output logic [4:0]           raddr2,
    input  logic [31:0]          rdata1,
    input  logic [31:0]          rdata2,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::id_out_t  out
);
    import decode_pkg::*;

    dec_t    dec;
    id_out_t nxt;
    logic    exc;
    ecode_t  ecode;

    assign dec    = dec_3r.hit ? dec_3r : dec_2ri12; // decoders never both hit
    assign raddr1 = in.inst[9:5];
    assign raddr2 = in.inst[14:10];

    always_comb begin
        exc   = 1'b1;
        ecode = ECODE_INE; // also the idle value when exc is low
        if (in.pc[1:0] != 2'b00) begin
            ecode = ECODE_ADEF;
        end else if (!dec.hit) begin
            ecode = ECODE_INE;
        end else if (dec.is_priv && plv != PLV_KERNEL) begin
            ecode = ECODE_IPE;
        end else if (dec.aluop == ALU_SYSCALL) begin
            ecode = ECODE_SYS;
        end else if (dec.aluop == ALU_BREAK) begin
            ecode = ECODE_BRK;
        end else begin
            exc = 1'b0;
        end
    end

    always_comb begin
        nxt.pc        = in.pc;
        nxt.inst      = in.inst;
        nxt.we        = dec.we & ~exc;
        nxt.waddr     = in.inst[4:0];
        nxt.aluop     = dec.aluop;
        nxt.alusel    = dec.alusel;
        nxt.imm       = dec.imm;
        nxt.rs1       = dec.re1 ? rdata1 : 32'b0;
        nxt.rs2       = dec.re2 ? rdata2 : 32'b0;
        nxt.is_priv   = dec.is_priv;
        nxt.invtlb_op = dec.invtlb_op;
        nxt.exc       = exc;
        nxt.ecode     = ecode;
    end

    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out <= nxt; // held while stalled
        end
    end

endmodule

// File: rtl/id_stage.sv
module id_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  decode_pkg::in_t      in,
    input  logic [1:0]           plv,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::id_out_t  out,
    input  logic                 wb_en,
    input  logic [4:0]           wb_addr,
    input  logic [31:0]          wb_data
);
    import decode_pkg::*;

    dec_t        dec_3r;
    dec_t        dec_2ri12;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;

    id_3r u_id_3r (
        .inst (in.inst),
        .dec  (dec_3r)
    );

    id_2ri12 u_id_2ri12 (
        .inst (in.inst),
        .dec  (dec_2ri12)
    );

    id_ctrl u_id_ctrl (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in        (in),
        .plv       (plv),
        .dec_3r    (dec_3r),
        .dec_2ri12 (dec_2ri12),
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (wb_en),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

endmodule

// File: testbench/id_stage_assertions.sv
module id_stage_assertions (
    input logic                clk,
    input logic                reset,
    input logic                in_valid,
    input logic                in_ready,
    input logic                out_valid,
    input logic                out_ready,
    input decode_pkg::id_out_t out
);
    int unsigned fail_count = 0; // read by the testbench

    reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid still high after a reset cycle");
        end

    accept_to_valid: assert property (@(posedge clk) disable iff (reset)
        in_valid && in_ready |=> out_valid)
        else begin
            fail_count++;
            $error("accepted instruction did not show up one cycle later");
        end

    // no accept and nothing held, so nothing may come out
    no_spurious_valid: assert property (@(posedge clk) disable iff (reset)
        !(in_valid && in_ready) && !(out_valid && !out_ready) |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high without an accepted instruction");
        end

    stall_holds: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else begin
            fail_count++;
            $error("output changed or dropped while stalled");
        end

    ready_rule: assert property (@(posedge clk) in_ready == (!out_valid || out_ready))
        else begin
            fail_count++;
            $error("in_ready does not follow out_valid and out_ready");
        end

    exc_blocks_we: assert property (@(posedge clk) disable iff (reset)
        out_valid && out.exc |-> !out.we)
        else begin
            fail_count++;
            $error("write enable set on an excepting instruction");
        end

endmodule

// File: testbench/tb_id_stage.sv
module tb_id_stage;
    import decode_pkg::*;

    localparam int N3R = 26;
    localparam int STIM_TOTAL = 4 + (32 + N3R * 4 + 1) + 48 + 36 + 60 + 32;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    in_t         in_pl;
    logic [1:0]  plv;
    logic        out_valid;
    logic        out_ready;
    id_out_t     out;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    logic [31:0] shadow [32]; // model copy of the register file
    id_out_t     exp_q [$];
    string       test_name = "reset";
    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned base_errors;
    int unsigned base_checks;
    int unsigned tests_passed = 0;
    int unsigned tests_failed = 0;
    logic        bp_on = 1'b0;

    logic [16:0] op3r [N3R] = '{
        OP_ADDW, OP_SUBW, OP_SLT, OP_SLTU, OP_NOR, OP_AND, OP_OR, OP_XOR, OP_SLLW,
        OP_SRLW, OP_SRAW, OP_MULW, OP_MULHW, OP_MULHWU, OP_DIVW, OP_MODW, OP_DIVWU,
        OP_BREAK, OP_SYSCALL, OP_SLLIW, OP_SRLIW, OP_SRAIW, OP_IDLE, OP_INVTLB,
        OP_DBAR, OP_IBAR
    };
    aluop_t alu3r [N3R] = '{
        ALU_ADDW, ALU_SUBW, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND, ALU_OR, ALU_XOR, ALU_SLLW,
        ALU_SRLW, ALU_SRAW, ALU_MULW, ALU_MULHW, ALU_MULHWU, ALU_DIVW, ALU_MODW, ALU_DIVWU,
        ALU_BREAK, ALU_SYSCALL, ALU_SLLIW, ALU_SRLIW, ALU_SRAIW, ALU_IDLE, ALU_INVTLB,
        ALU_NOP, ALU_NOP
    };
    logic [9:0] op2 [6] = '{OP_ADDIW, OP_SLTI, OP_SLTUI, OP_ANDI, OP_ORI, OP_XORI};
    aluop_t     alu2 [6] = '{ALU_ADDW, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR};

    id_stage u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in        (in_pl),
        .plv       (plv),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    bind id_stage id_stage_assertions u_assertions (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        out_ready <= 1'b1;
        forever begin
            @(posedge clk);
            out_ready <= bp_on ? 1'($urandom()) : 1'b1;
        end
    end

    initial begin
        #(STIM_TOTAL * 40 * 4 + 10 * 40);
        $display("timeout: run did not finish within %0d time units", STIM_TOTAL * 160 + 400);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic id_out_t predict(in_t x, logic [1:0] p);
        id_out_t e;
        logic    hit;
        logic    re1;
        logic    re2;
        e = '0;
        hit = 1'b0;
        re1 = 1'b0;
        re2 = 1'b0;
        e.pc = x.pc;
        e.inst = x.inst;
        e.waddr = x.inst[4:0];
        for (int i = 0; i < N3R; i++) begin
            if (x.inst[31:15] == op3r[i]) begin
                hit = 1'b1;
                e.aluop = alu3r[i];
            end
        end
        if (hit) begin
            re1 = 1'b1;
            re2 = 1'b1;
            e.we = 1'b1;
            e.alusel = SEL_ARITH;
            case (e.aluop)
                ALU_SLLIW, ALU_SRLIW, ALU_SRAIW: begin
                    re2 = 1'b0;
                    e.imm = {27'b0, x.inst[14:10]};
                end
                ALU_MULW, ALU_MULHW, ALU_MULHWU, ALU_DIVW, ALU_DIVWU, ALU_MODW: begin
                    e.alusel = SEL_MUL;
                end
                ALU_INVTLB: begin
                    e.we = 1'b0;
                    e.alusel = SEL_NOP;
                    e.is_priv = 1'b1;
                    e.invtlb_op = x.inst[4:0];
                end
                ALU_IDLE, ALU_BREAK, ALU_SYSCALL, ALU_NOP: begin
                    e.we = 1'b0;
                    e.alusel = SEL_NOP;
                    e.is_priv = (e.aluop == ALU_IDLE);
                    re1 = 1'b0;
                    re2 = 1'b0;
                end
                default: ;
            endcase
        end
        for (int i = 0; i < 6; i++) begin
            if (!hit && x.inst[31:22] == op2[i]) begin
                hit = 1'b1;
                re1 = 1'b1;
                e.we = 1'b1;
                e.alusel = SEL_ARITH;
                e.aluop = alu2[i];
                e.imm = (i >= 3) ? {20'b0, x.inst[21:10]} : {{20{x.inst[21]}}, x.inst[21:10]};
            end
        end
        e.rs1 = re1 ? shadow[x.inst[9:5]] : 32'b0;
        e.rs2 = re2 ? shadow[x.inst[14:10]] : 32'b0;
        e.exc = 1'b1;
        if (x.pc[1:0] != 2'b00) e.ecode = ECODE_ADEF;
        else if (!hit) e.ecode = ECODE_INE;
        else if (e.is_priv && p != 2'd0) e.ecode = ECODE_IPE;
        else if (e.aluop == ALU_SYSCALL) e.ecode = ECODE_SYS;
        else if (e.aluop == ALU_BREAK) e.ecode = ECODE_BRK;
        else e.exc = 1'b0;
        if (e.exc) e.we = 1'b0;
        return e;
    endfunction

    // ecode carries no meaning without exc
    function automatic id_out_t drop_idle_ecode(id_out_t v);
        if (!v.exc) v.ecode = ECODE_INE;
        return v;
    endfunction

    function automatic int unsigned total_errors();
        return errors + u_dut.u_assertions.fail_count;
    endfunction

    function automatic logic [31:0] aligned_pc();
        return $urandom() & 32'hffff_fffc;
    endfunction

    always @(posedge clk) begin
        id_out_t exp_v;
        if (reset) begin
            shadow = '{default: '0};
        end else begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("%s: output transfer with no instruction outstanding", test_name);
                    errors++;
                end else begin
                    exp_v = exp_q.pop_front();
                    checks++;
                    if (drop_idle_ecode(exp_v) !== drop_idle_ecode(out)) begin
                        $display("[FAIL] %s: expected %h, actual %h", test_name, exp_v, out);
                        errors++;
                    end
                end
            end
            if (in_valid && in_ready) exp_q.push_back(predict(in_pl, plv));
            if (wb_en && wb_addr != 5'd0) shadow[wb_addr] = wb_data; // after the read
        end
    end

    task automatic send(input logic [31:0] pc, input logic [31:0] inst, input logic [1:0] p);
        in_valid <= 1'b1;
        in_pl <= '{pc: pc, inst: inst};
        plv <= p;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
        wb_en <= 1'b1;
        wb_addr <= a;
        wb_data <= d;
        @(posedge clk);
        wb_en <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        base_errors = total_errors();
        base_checks = checks;
    endtask

    task automatic end_test();
        int unsigned fails;
        @(posedge clk); // last accept is queued by now
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        fails = total_errors() - base_errors;
        if (fails == 0) tests_passed++;
        else tests_failed++;
        $display("%-16s %s, %0d outputs checked, %0d errors", test_name,
                 (fails == 0) ? "ok" : "bad", checks - base_checks, fails);
    endtask

    task automatic check_latency();
        begin_test("reset_latency");
        for (int k = 0; k < 4; k++) begin
            send(aligned_pc(), {OP_ADDW, 15'($urandom())}, 2'd0);
            repeat (2) @(posedge clk); // isolated accepts
        end
        end_test();
    endtask

    task automatic decode_3r_ops();
        logic [31:0] r;
        begin_test("decode_3r");
        for (int a = 0; a < 32; a++) write_reg(a[4:0], $urandom()); // r0 write too
        send(aligned_pc(), {OP_ADDW, 15'b0}, 2'd0);
        for (int i = 0; i < N3R; i++) begin
            for (int k = 0; k < 4; k++) begin
                r = $urandom();
                send(aligned_pc(), {op3r[i], r[14:0]}, 2'd0);
            end
        end
        end_test();
    endtask

    task automatic decode_2ri12_ops();
        logic [31:0] r;
        begin_test("decode_2ri12");
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 8; k++) begin
                r = $urandom();
                send(aligned_pc(), {op2[i], r[21:0]}, 2'd0);
            end
        end
        end_test();
    endtask

    task automatic rank_exceptions();
        logic [31:0] r;
        begin_test("exceptions");
        for (int k = 0; k < 4; k++) begin
            r = $urandom();
            send(aligned_pc(), {10'h3ff, r[21:0]}, 2'd0); // unknown opcode
            send(aligned_pc() + 32'(k % 3 + 1), {10'h3ff, r[21:0]}, 2'd0);
            send(aligned_pc() + 32'(k % 3 + 1), {OP_ADDW, r[14:0]}, 2'd0); // write masked
            send(aligned_pc(), {OP_IDLE, r[14:0]}, 2'd3);
            send(aligned_pc(), {OP_INVTLB, r[14:0]}, 2'd3);
            send(aligned_pc(), {OP_IDLE, r[14:0]}, 2'd0);
            send(aligned_pc(), {OP_INVTLB, r[14:0]}, 2'd0);
            send(aligned_pc(), {OP_SYSCALL, r[14:0]}, 2'(k));
            send(aligned_pc(), {OP_BREAK, r[14:0]}, 2'(k));
        end
        end_test();
    endtask

    task automatic stall_output();
        logic [31:0] r;
        begin_test("backpressure");
        bp_on = 1'b1;
        for (int k = 0; k < 60; k++) begin
            r = $urandom();
            if (r[31]) send(aligned_pc(), {op3r[$urandom_range(N3R - 1)], r[14:0]}, 2'd0);
            else send(aligned_pc(), {op2[$urandom_range(5)], r[21:0]}, 2'd0);
        end
        end_test();
        bp_on = 1'b0;
    endtask

    task automatic writeback_readback();
        logic [4:0] a;
        begin_test("writeback_read");
        for (int k = 0; k < 16; k++) begin
            a = (k == 0) ? 5'd0 : 5'($urandom());
            write_reg(a, $urandom());
            send(aligned_pc(), {OP_ADDW, a, a, 5'($urandom())}, 2'd0);
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'h42a7));
        reset <= 1'b1;
        in_valid <= 1'b0;
        in_pl <= '0;
        plv <= 2'd0;
        wb_en <= 1'b0;
        wb_addr <= 5'd0;
        wb_data <= 32'd0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_latency();
        decode_3r_ops();
        decode_2ri12_ops();
        rank_exceptions();
        stall_output();
        writeback_readback();
        $display("summary: %0d tests ok, %0d tests bad", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/decode_pkg.sv
rtl/id_3r.sv
rtl/id_2ri12.sv
rtl/regfile.sv
rtl/id_ctrl.sv
rtl/id_stage.sv
testbench/id_stage_assertions.sv
testbench/tb_id_stage.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= tb_id_stage
FILELIST    ?= project.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) 2>&1 | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
